/* Bender.yml */
package:
  name: lkh_route_stage

sources:
  - src/route_pkg.sv
  - src/flit_fifo.sv
  - src/next_router_select.sv
  - src/xy_lookahead_route.sv
  - src/lkh_route_ctrl.sv
  - src/lkh_route_stage.sv
  - target: test
    files:
      - testbench/lkh_route_properties.sv
      - testbench/tb_lkh_route_stage.sv

/* compile.f */
src/route_pkg.sv
src/flit_fifo.sv
src/next_router_select.sv
src/xy_lookahead_route.sv
src/lkh_route_ctrl.sv
src/lkh_route_stage.sv
testbench/lkh_route_properties.sv
testbench/tb_lkh_route_stage.sv

/* src/flit_fifo.sv */
`default_nettype none

module flit_fifo #(
    parameter int DEPTH = 4,
    parameter int W     = 8
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         push,
    input  logic [W-1:0] push_data,
    input  logic         pop,
    output logic [W-1:0] head_data,
    output logic         empty,
    output logic         full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [W-1:0]  mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count; // entries held

    // pointer wrap for depths that are not a power of two
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
        if (ptr == AW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle or push and pop together
            endcase
        end
    end

    // storage only, no reset needed on the entries
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign head_data = mem[rd_ptr]; // head visible the cycle after the write
    assign empty     = (count == '0);
    assign full      = (count == CW'(DEPTH));

endmodule

`default_nettype wire

/* src/lkh_route_ctrl.sv */
`default_nettype none

module lkh_route_ctrl #(
    parameter int OUT_CREDITS = 2
) (
    input  logic clk,
    input  logic arst_n,
    input  logic fifo_empty,
    input  logic out_credit,
    output logic pop,
    output logic stage_load,
    output logic in_credit,
    output logic out_valid
);

    localparam int CW = $clog2(OUT_CREDITS + 1);

    logic [CW-1:0] credit_cnt; // downstream slots still free
    logic          credit_ok;

    // the flit sitting in the stage register has not been counted yet,
    // so keep one credit aside for it while out_valid is high
    assign credit_ok = (credit_cnt > CW'(out_valid));

    assign pop        = !fifo_empty && credit_ok;
    assign stage_load = pop; // buffer head moves into the stage register
    assign in_credit  = pop; // freed buffer slot goes back upstream

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop; // one cycle per loaded flit
        end
    end

    // send and return in the same cycle cancel out
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= CW'(OUT_CREDITS);
        end else begin
            case ({out_valid, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/lkh_route_stage.sv */
`default_nettype none

module lkh_route_stage import route_pkg::*; #(
    parameter int INBUF_DEPTH = 4,
    parameter int OUT_CREDITS = 2,
    parameter int PAYLOAD_W   = 16
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [RAW-1:0]       cur_addr,      // this router, strap
    input  logic                 in_valid,
    input  logic [RAW-1:0]       in_dest_addr,
    input  port_e                in_destport,   // chosen by the previous router
    input  logic [PAYLOAD_W-1:0] in_payload,
    output logic                 in_credit,
    output logic                 out_valid,
    output logic [RAW-1:0]       out_dest_addr,
    output port_e                out_lkdestport, // for the next router
    output logic [PAYLOAD_W-1:0] out_payload,
    input  logic                 out_credit
);

    localparam int FLIT_W = RAW + PW + PAYLOAD_W; // {dest, port, payload}

    logic                 fifo_pop;
    logic                 fifo_empty;
    logic                 stage_load;
    logic [FLIT_W-1:0]    head_data;
    logic [RAW-1:0]       head_dest_addr;
    port_e                head_destport;
    logic [PAYLOAD_W-1:0] head_payload;
    logic [XW-1:0]        next_x;
    logic [YW-1:0]        next_y;

    assign head_dest_addr = head_data[FLIT_W-1 -: RAW];
    assign head_destport  = port_e'(head_data[PAYLOAD_W +: PW]);
    assign head_payload   = head_data[PAYLOAD_W-1:0];

    flit_fifo #(
        .DEPTH (INBUF_DEPTH),
        .W     (FLIT_W)
    ) u_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (in_valid),
        .push_data ({in_dest_addr, in_destport, in_payload}),
        .pop       (fifo_pop),
        .head_data (head_data),
        .empty     (fifo_empty),
        .full      ()          // upstream credits keep it from filling
    );

    next_router_select u_next (
        .cur_addr (cur_addr),
        .destport (head_destport),
        .next_x   (next_x),
        .next_y   (next_y)
    );

    xy_lookahead_route #(
        .PAYLOAD_W (PAYLOAD_W)
    ) u_route (
        .clk            (clk),
        .arst_n         (arst_n),
        .load           (stage_load),
        .next_x         (next_x),
        .next_y         (next_y),
        .dest_addr      (head_dest_addr),
        .destport       (head_destport),
        .payload        (head_payload),
        .out_dest_addr  (out_dest_addr),
        .out_lkdestport (out_lkdestport),
        .out_payload    (out_payload)
    );

    lkh_route_ctrl #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .fifo_empty (fifo_empty),
        .out_credit (out_credit),
        .pop        (fifo_pop),
        .stage_load (stage_load),
        .in_credit  (in_credit),
        .out_valid  (out_valid)
    );

endmodule

`default_nettype wire

/* src/next_router_select.sv */
`default_nettype none

module next_router_select import route_pkg::*; (
    input  logic [RAW-1:0] cur_addr,
    input  port_e          destport,
    output logic [XW-1:0]  next_x,
    output logic [YW-1:0]  next_y
);

    logic [XW-1:0] cur_x;
    logic [YW-1:0] cur_y;

    assign cur_x = cur_addr[XW-1:0];
    assign cur_y = cur_addr[RAW-1:XW];

    // neighbor reached through destport, in mesh coordinates
    always_comb begin
        case (destport)
            port_east: begin
                next_x = cur_x + 1'b1;
                next_y = cur_y;
            end
            port_north: begin
                next_x = cur_x;
                next_y = cur_y + 1'b1;
            end
            port_west: begin
                next_x = cur_x - 1'b1;
                next_y = cur_y;
            end
            port_south: begin
                next_x = cur_x;
                next_y = cur_y - 1'b1;
            end
            default: begin // local, flit stays at this router
                next_x = cur_x;
                next_y = cur_y;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/route_pkg.sv */
`default_nettype none

package route_pkg;

    // mesh dimensions, fixed for the whole design
    localparam int NX = 4; // columns
    localparam int NY = 4; // rows

    // coordinate widths, never below one bit
    localparam int XW = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW = (NY > 1) ? $clog2(NY) : 1;

    // router address is {y, x}, endpoint address is the same
    localparam int RAW = YW + XW;

    localparam int PORT_NUM = 5;
    localparam int PW = $clog2(PORT_NUM); // 3 bits

    // router port numbering
    typedef enum logic [PW-1:0] {
        port_local = 0, // ejection to the endpoint
        port_east  = 1, // x + 1
        port_north = 2, // y + 1
        port_west  = 3, // x - 1
        port_south = 4  // y - 1
    } port_e;

endpackage

`default_nettype wire

/* src/xy_lookahead_route.sv */
`default_nettype none

module xy_lookahead_route import route_pkg::*; #(
    parameter int PAYLOAD_W = 16
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 load,
    input  logic [XW-1:0]        next_x,
    input  logic [YW-1:0]        next_y,
    input  logic [RAW-1:0]       dest_addr,
    input  port_e                destport,
    input  logic [PAYLOAD_W-1:0] payload,
    output logic [RAW-1:0]       out_dest_addr,
    output port_e                out_lkdestport,
    output logic [PAYLOAD_W-1:0] out_payload
);

    logic [XW-1:0] dest_x;
    logic [YW-1:0] dest_y;
    port_e         lk_port;

    assign dest_x = dest_addr[XW-1:0];
    assign dest_y = dest_addr[RAW-1:XW];

    // XY decision as the next router would make it
    always_comb begin
        if (destport == port_local) begin
            lk_port = port_local; // ejected here, no next router
        end else if (dest_x > next_x) begin
            lk_port = port_east;
        end else if (dest_x < next_x) begin
            lk_port = port_west;
        end else if (dest_y > next_y) begin
            lk_port = port_north;
        end else if (dest_y < next_y) begin
            lk_port = port_south;
        end else begin
            lk_port = port_local; // next router is the destination
        end
    end

    // stage register, header fields
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_dest_addr  <= '0;
            out_lkdestport <= port_local;
        end else if (load) begin
            out_dest_addr  <= dest_addr;
            out_lkdestport <= lk_port;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_payload <= payload; // passes through untouched
        end
    end

endmodule

`default_nettype wire

/* testbench/lkh_route_properties.sv */
`default_nettype none

module lkh_route_properties #(
    parameter int OUT_CREDITS = 2,
    parameter int CW          = $clog2(OUT_CREDITS + 1)
) (
    input logic          clk,
    input logic          arst_n,
    input logic          push,       // upstream write into the input buffer
    input logic          fifo_full,
    input logic          out_valid,
    input logic [CW-1:0] credit_cnt  // downstream credits held by the stage
);

    int fail_count = 0; // assertion failures so far

    // upstream must hold a credit for every flit it sends
    no_push_when_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(push && fifo_full)
    ) else begin
        $error("flit pushed into a full input buffer");
        fail_count++;
    end

    // a flit only leaves while a downstream slot is free
    no_send_without_credit: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid |-> (credit_cnt != '0)
    ) else begin
        $error("out_valid high with the credit counter at zero");
        fail_count++;
    end

    counter_in_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        credit_cnt <= CW'(OUT_CREDITS)
    ) else begin
        $error("credit counter above its initial value");
        fail_count++;
    end

endmodule

bind lkh_route_stage lkh_route_properties #(
    .OUT_CREDITS (OUT_CREDITS)
) u_props (
    .clk        (clk),
    .arst_n     (arst_n),
    .push       (in_valid),
    .fifo_full  (u_fifo.full),
    .out_valid  (out_valid),
    .credit_cnt (u_ctrl.credit_cnt)
);

`default_nettype wire

/* testbench/tb_lkh_route_stage.sv */
`default_nettype none

module tb_lkh_route_stage
    import route_pkg::*;
();

    localparam int INBUF_DEPTH = 4;
    localparam int OUT_CREDITS = 2;
    localparam int PAYLOAD_W   = 16;
    localparam int WAIT_LIMIT  = 2000; // cycles any single wait may take

    logic                 clk;
    logic                 arst_n;
    logic [RAW-1:0]       cur_addr;
    logic                 in_valid;
    logic [RAW-1:0]       in_dest_addr;
    port_e                in_destport;
    logic [PAYLOAD_W-1:0] in_payload;
    logic                 in_credit;
    logic                 out_valid;
    logic [RAW-1:0]       out_dest_addr;
    port_e                out_lkdestport;
    logic [PAYLOAD_W-1:0] out_payload;
    logic                 out_credit;

    int seed = 29;
    int up_credits;    // upstream view of free buffer slots
    int sent_count;
    int rcv_count;
    int credit_pulses;
    bit withhold;      // downstream keeps its credits back
    bit credit_last;   // in_credit one cycle earlier

    logic [RAW-1:0]       exp_addr[$];
    port_e                exp_port[$];
    logic [PAYLOAD_W-1:0] exp_payload[$];
    int                   credit_due[$]; // cycles left before each credit returns

    lkh_route_stage #(
        .INBUF_DEPTH (INBUF_DEPTH),
        .OUT_CREDITS (OUT_CREDITS),
        .PAYLOAD_W   (PAYLOAD_W)
    ) u_dut (
        .clk            (clk),
        .arst_n         (arst_n),
        .cur_addr       (cur_addr),
        .in_valid       (in_valid),
        .in_dest_addr   (in_dest_addr),
        .in_destport    (in_destport),
        .in_payload     (in_payload),
        .in_credit      (in_credit),
        .out_valid      (out_valid),
        .out_dest_addr  (out_dest_addr),
        .out_lkdestport (out_lkdestport),
        .out_payload    (out_payload),
        .out_credit     (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_port(input string name, input port_e got, input port_e exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input logic [RAW-1:0] got,
                              input logic [RAW-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_payload(input string name, input logic [PAYLOAD_W-1:0] got,
                                 input logic [PAYLOAD_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // a port is legal if it stays inside the mesh, local only at the destination
    function automatic bit port_legal(input logic [RAW-1:0] cur, input logic [RAW-1:0] dest,
                                      input port_e port);
        int x;
        int y;
        x = cur[XW-1:0];
        y = cur[RAW-1:XW];
        case (port)
            port_east:  return x < NX - 1;
            port_north: return y < NY - 1;
            port_west:  return x > 0;
            port_south: return y > 0;
            default:    return dest == cur;
        endcase
    endfunction

    // XY routing as the neighbor behind the current port would do it
    function automatic port_e compute_lkdestport(input logic [RAW-1:0] cur,
                                                 input logic [RAW-1:0] dest, input port_e port);
        int nx;
        int ny;
        int dx;
        int dy;
        nx = cur[XW-1:0];
        ny = cur[RAW-1:XW];
        dx = dest[XW-1:0];
        dy = dest[RAW-1:XW];
        case (port)
            port_east:  nx = nx + 1;
            port_north: ny = ny + 1;
            port_west:  nx = nx - 1;
            port_south: ny = ny - 1;
            default:    return port_local; // flit ejects at this router
        endcase
        if (dx > nx) begin
            return port_east;
        end else if (dx < nx) begin
            return port_west;
        end else if (dy > ny) begin
            return port_north;
        end else if (dy < ny) begin
            return port_south;
        end
        return port_local;
    endfunction

    task automatic pick_port(input logic [RAW-1:0] cur, input logic [RAW-1:0] dest,
                             output port_e port);
        port_e legal[$];
        for (int p = 0; p < PORT_NUM; p++) begin
            if (port_legal(cur, dest, port_e'(p))) begin
                legal.push_back(port_e'(p));
            end
        end
        port = legal[$unsigned($random(seed)) % legal.size()];
    endtask

    // returns right after the edge that drives the flit
    task automatic send_flit(input logic [RAW-1:0] dest, input port_e port,
                             input logic [PAYLOAD_W-1:0] payload);
        int waited;
        waited = 0;
        @(posedge clk);
        while (up_credits == 0) begin
            in_valid <= 1'b0;
            if (waited == WAIT_LIMIT) begin
                abort_run("no upstream credit came back before the timeout");
            end
            waited++;
            @(posedge clk);
        end
        in_valid     <= 1'b1;
        in_dest_addr <= dest;
        in_destport  <= port;
        in_payload   <= payload;
        up_credits--;
        sent_count++;
        exp_addr.push_back(dest);
        exp_port.push_back(compute_lkdestport(cur_addr, dest, port));
        exp_payload.push_back(payload);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        while (exp_addr.size() != 0 || up_credits != INBUF_DEPTH || credit_due.size() != 0) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("flits did not drain before the timeout");
            end
            waited++;
            @(negedge clk);
        end
    endtask

    // scoreboard and upstream credit monitor
    always @(negedge clk) begin
        if (arst_n) begin
            if (u_dut.u_props.fail_count != 0) begin
                abort_run("a credit protocol assertion fired");
            end
            if (in_credit) begin
                credit_pulses++;
                up_credits++;
            end
            if (credit_pulses > sent_count) begin
                abort_run("in_credit pulsed more often than flits were sent");
            end
            // each popped flit shows up on the output one cycle after its credit pulse
            if (out_valid !== credit_last) begin
                abort_run("out_valid did not follow an in_credit pulse by one cycle");
            end
            credit_last = in_credit;
            if (out_valid) begin
                if (exp_addr.size() == 0) begin
                    abort_run("out_valid rose with no flit expected");
                end
                check_addr("out_dest_addr", out_dest_addr, exp_addr.pop_front());
                check_port("out_lkdestport", out_lkdestport, exp_port.pop_front());
                check_payload("out_payload", out_payload, exp_payload.pop_front());
                rcv_count++;
                credit_due.push_back($unsigned($random(seed)) % 4);
            end
        end
    end

    // downstream returns one credit per received flit after a short delay
    always @(posedge clk) begin
        out_credit <= 1'b0;
        if (!withhold && credit_due.size() != 0) begin
            if (credit_due[0] == 0) begin
                void'(credit_due.pop_front());
                out_credit <= 1'b1;
            end else begin
                credit_due[0] = credit_due[0] - 1;
            end
        end
    end

    initial begin
        int            latency;
        bit            out_seen;
        int            base;
        logic [RAW-1:0] router;
        logic [RAW-1:0] dest;
        port_e         port;

        arst_n        = 1'b0;
        cur_addr      = '0;
        in_valid      = 1'b0;
        in_dest_addr  = '0;
        in_destport   = port_local;
        in_payload    = '0;
        out_credit    = 1'b0;
        withhold      = 1'b0;
        credit_last   = 1'b0;
        up_credits    = INBUF_DEPTH;
        sent_count    = 0;
        rcv_count     = 0;
        credit_pulses = 0;

        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        if (out_valid !== 1'b0 || in_credit !== 1'b0) begin
            abort_run("out_valid or in_credit is high right after reset");
        end

        // single flit, latency from the in_valid edge
        @(posedge clk);
        cur_addr <= RAW'(5); // router (1,1)
        send_flit(RAW'(11), port_east, 16'h1234);
        latency  = 0;
        out_seen = 1'b0;
        while (!out_seen) begin
            @(posedge clk);
            in_valid <= 1'b0;
            latency++;
            @(negedge clk);
            out_seen = out_valid;
            if (!out_seen && latency == WAIT_LIMIT) begin
                abort_run("first flit never reached the output");
            end
        end
        if (latency != 2) begin
            abort_run($sformatf("first flit took %0d cycles instead of 2", latency));
        end

        // every router, every destination, every legal current port
        for (int r = 0; r < NX * NY; r++) begin
            wait_drain();
            @(posedge clk);
            cur_addr <= RAW'(r);
            for (int d = 0; d < NX * NY; d++) begin
                for (int p = 0; p < PORT_NUM; p++) begin
                    if (port_legal(RAW'(r), RAW'(d), port_e'(p))) begin
                        send_flit(RAW'(d), port_e'(p), PAYLOAD_W'($random(seed)));
                    end
                end
            end
        end

        // random traffic with gaps, router changes every 50 flits
        router = '0;
        for (int i = 0; i < 200; i++) begin
            if (i % 50 == 0) begin
                wait_drain();
                router = RAW'($unsigned($random(seed)) % (NX * NY));
                @(posedge clk);
                cur_addr <= router;
            end
            dest = RAW'($unsigned($random(seed)) % (NX * NY));
            pick_port(router, dest, port);
            send_flit(dest, port, PAYLOAD_W'($random(seed)));
            if ($unsigned($random(seed)) % 4 == 0) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
        end

        // back-pressure: only OUT_CREDITS flits may pass while credits are held
        wait_drain();
        withhold = 1'b1;
        base     = rcv_count;
        for (int i = 0; i < OUT_CREDITS + INBUF_DEPTH; i++) begin
            dest = RAW'($unsigned($random(seed)) % (NX * NY));
            pick_port(router, dest, port);
            send_flit(dest, port, PAYLOAD_W'($random(seed)));
        end
        repeat (20) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
        if (rcv_count - base != OUT_CREDITS) begin
            abort_run($sformatf("%0d flits passed without downstream credits, expected %0d",
                                rcv_count - base, OUT_CREDITS));
        end
        @(negedge clk);
        withhold = 1'b0;
        wait_drain();

        if (credit_pulses != sent_count || rcv_count != sent_count) begin
            abort_run($sformatf("%0d sent, %0d received, %0d upstream credits returned",
                                sent_count, rcv_count, credit_pulses));
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
